// ==== calc_macros.svh ====
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// Operand and result width
`define CALC_WIDTH 16

// Decimal digits on the readout
`define CALC_DIGITS 5

// Two radicand bits are consumed per root step
`define CALC_ROOT_STEPS (`CALC_WIDTH / 2)

`endif

// ==== calc_pkg.sv ====
`include "calc_macros.svh"

package calc_pkg;

	typedef logic [`CALC_WIDTH-1:0] data_t;

	// Full product before the overflow check
	typedef logic [2*`CALC_WIDTH-1:0] prod_t;

	typedef enum logic [1:0] {
		OP_MUL  = 2'd0,
		OP_DIV  = 2'd1,
		OP_SQRT = 2'd2
	} op_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_HAVE_X,
		S_READY_OPS,
		S_CHECK,
		S_RUN,
		S_DONE
	} ctrl_state_t;

	typedef enum logic {
		U_IDLE,
		U_BUSY
	} unit_state_t;

	typedef logic [3:0] bcd_t;

	// Bit 0 is segment a, bit 6 is segment g
	typedef logic [6:0] seg_t;

endpackage

// ==== alu_share_if.sv ====
`timescale 1ns/1ps
`include "calc_macros.svh"

interface alu_share_if;

	// One bit wider than a data word to hold carries and shifted remainders
	logic                 req;
	logic [`CALC_WIDTH:0] op_a;
	logic [`CALC_WIDTH:0] op_b;
	logic                 sub;
	logic                 gnt;
	logic [`CALC_WIDTH:0] res;
	logic                 no_borrow;

	modport unit (output req, op_a, op_b, sub, input gnt, res, no_borrow);

	modport arbiter (input req, op_a, op_b, sub, output gnt, res, no_borrow);

endinterface

// ==== alu_arbiter.sv ====
`timescale 1ns/1ps
`include "calc_macros.svh"

module alu_arbiter import calc_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	alu_share_if.arbiter mult_port,
	alu_share_if.arbiter div_port,
	alu_share_if.arbiter sqrt_port
);

	op_t                    owner;
	logic [2:0]             gnt_vec;
	logic [2:0]             last_gnt;
	logic [`CALC_WIDTH:0]   a;
	logic [`CALC_WIDTH:0]   b;
	logic [`CALC_WIDTH:0]   b_eff;
	logic                   sub;
	logic [`CALC_WIDTH+1:0] sum;

	// Fixed priority, multiply first
	always_comb begin
		gnt_vec = 3'b000;
		owner   = OP_SQRT;
		if (mult_port.req) begin
			gnt_vec[0] = 1'b1;
			owner      = OP_MUL;
		end else if (div_port.req) begin
			gnt_vec[1] = 1'b1;
			owner      = OP_DIV;
		end else if (sqrt_port.req) begin
			gnt_vec[2] = 1'b1;
		end
	end

	always_comb begin
		case (owner)
			OP_MUL: begin
				a   = mult_port.op_a;
				b   = mult_port.op_b;
				sub = mult_port.sub;
			end
			OP_DIV: begin
				a   = div_port.op_a;
				b   = div_port.op_b;
				sub = div_port.sub;
			end
			default: begin
				a   = sqrt_port.op_a;
				b   = sqrt_port.op_b;
				sub = sqrt_port.sub;
			end
		endcase
		// Subtract as a plus inverted b plus one
		b_eff = sub ? ~b : b;
		sum   = {1'b0, a} + {1'b0, b_eff} + {{(`CALC_WIDTH+1){1'b0}}, sub};
	end

	assign mult_port.gnt       = gnt_vec[0];
	assign div_port.gnt        = gnt_vec[1];
	assign sqrt_port.gnt       = gnt_vec[2];
	assign mult_port.res       = sum[`CALC_WIDTH:0];
	assign div_port.res        = sum[`CALC_WIDTH:0];
	assign sqrt_port.res       = sum[`CALC_WIDTH:0];
	// Carry out of a subtraction means a >= b
	assign mult_port.no_borrow = sub ? sum[`CALC_WIDTH+1] : 1'b1;
	assign div_port.no_borrow  = sub ? sum[`CALC_WIDTH+1] : 1'b1;
	assign sqrt_port.no_borrow = sub ? sum[`CALC_WIDTH+1] : 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_gnt <= 3'b000;
		end else begin
			last_gnt <= gnt_vec;
		end
	end

endmodule

// ==== seq_mult.sv ====
`timescale 1ns/1ps
`include "calc_macros.svh"

module seq_mult import calc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  go,
	input  data_t mc,
	input  data_t mp,
	output logic  done,
	output prod_t prod,
	alu_share_if.unit alu
);

	localparam int STEPS = `CALC_WIDTH;
	localparam int CW = $clog2(STEPS);
	localparam logic [CW-1:0] LAST = CW'(STEPS - 1);

	unit_state_t   state;
	logic [CW-1:0] step_cnt;
	logic [CW-1:0] cur_cnt;
	data_t         mc_q;
	data_t         cur_mc;
	prod_t         acc;
	prod_t         cur_acc;

	// The go cycle already performs the first step on the fresh operands
	always_comb begin
		cur_mc  = go ? mc : mc_q;
		cur_acc = go ? {{`CALC_WIDTH{1'b0}}, mp} : acc;
		cur_cnt = go ? '0 : step_cnt;
	end

	assign alu.req  = go || (state == U_BUSY);
	assign alu.sub  = 1'b0;
	assign alu.op_a = {1'b0, cur_acc[2*`CALC_WIDTH-1:`CALC_WIDTH]};
	assign alu.op_b = cur_acc[0] ? {1'b0, cur_mc} : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= U_IDLE;
			step_cnt <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (alu.req && alu.gnt) begin
				if (cur_cnt == LAST) begin
					state <= U_IDLE;
					done  <= 1'b1;
				end else begin
					state    <= U_BUSY;
					step_cnt <= cur_cnt + 1'b1;
				end
			end else if (go) begin
				state    <= U_BUSY;
				step_cnt <= '0;
			end
		end
	end

	// Sum with carry goes on top, multiplier bits fall off the bottom
	always_ff @(posedge clk) begin
		if (go) begin
			mc_q <= mc;
		end
		if (alu.req && alu.gnt) begin
			acc <= {alu.res, cur_acc[`CALC_WIDTH-1:1]};
		end else if (go) begin
			acc <= cur_acc;
		end
	end

	assign prod = acc;

endmodule

// ==== seq_div.sv ====
`timescale 1ns/1ps
`include "calc_macros.svh"

module seq_div import calc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  go,
	input  data_t dividend,
	input  data_t divisor,
	output logic  done,
	output data_t quot,
	output data_t rem,
	alu_share_if.unit alu
);

	localparam int STEPS = `CALC_WIDTH;
	localparam int CW = $clog2(STEPS);
	localparam logic [CW-1:0] LAST = CW'(STEPS - 1);

	unit_state_t          state;
	logic [CW-1:0]        step_cnt;
	logic [CW-1:0]        cur_cnt;
	data_t                quot_q;
	data_t                rem_q;
	data_t                dvs_q;
	data_t                cur_quot;
	data_t                cur_rem;
	data_t                cur_dvs;
	logic [`CALC_WIDTH:0] partial;

	always_comb begin
		cur_quot = go ? dividend : quot_q;
		cur_rem  = go ? '0 : rem_q;
		cur_dvs  = go ? divisor : dvs_q;
		cur_cnt  = go ? '0 : step_cnt;
		// Next dividend bit shifted into the partial remainder
		partial  = {cur_rem, cur_quot[`CALC_WIDTH-1]};
	end

	assign alu.req  = go || (state == U_BUSY);
	assign alu.sub  = 1'b1;
	assign alu.op_a = partial;
	assign alu.op_b = {1'b0, cur_dvs};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= U_IDLE;
			step_cnt <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (alu.req && alu.gnt) begin
				if (cur_cnt == LAST) begin
					state <= U_IDLE;
					done  <= 1'b1;
				end else begin
					state    <= U_BUSY;
					step_cnt <= cur_cnt + 1'b1;
				end
			end else if (go) begin
				state    <= U_BUSY;
				step_cnt <= '0;
			end
		end
	end

	// Failed trial restores the shifted partial remainder
	always_ff @(posedge clk) begin
		if (alu.req && alu.gnt) begin
			quot_q <= {cur_quot[`CALC_WIDTH-2:0], alu.no_borrow};
			rem_q  <= alu.no_borrow ? alu.res[`CALC_WIDTH-1:0] : partial[`CALC_WIDTH-1:0];
			dvs_q  <= cur_dvs;
		end else if (go) begin
			quot_q <= cur_quot;
			rem_q  <= cur_rem;
			dvs_q  <= cur_dvs;
		end
	end

	assign quot = quot_q;
	assign rem  = rem_q;

endmodule

// ==== seq_sqrt.sv ====
`timescale 1ns/1ps
`include "calc_macros.svh"

module seq_sqrt import calc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  go,
	input  data_t radicand,
	output logic  done,
	output data_t root,
	output data_t rem,
	alu_share_if.unit alu
);

	localparam int STEPS = `CALC_ROOT_STEPS;
	localparam int CW = $clog2(STEPS);
	localparam logic [CW-1:0] LAST = CW'(STEPS - 1);

	unit_state_t          state;
	logic [CW-1:0]        step_cnt;
	logic [CW-1:0]        cur_cnt;
	data_t                rad_q;
	data_t                root_q;
	data_t                rem_q;
	data_t                cur_rad;
	data_t                cur_root;
	data_t                cur_rem;
	logic [`CALC_WIDTH:0] rem_sh;

	// Remainder never exceeds twice the root, so its top bit is always zero
	always_comb begin
		cur_rad  = go ? radicand : rad_q;
		cur_root = go ? '0 : root_q;
		cur_rem  = go ? '0 : rem_q;
		cur_cnt  = go ? '0 : step_cnt;
		rem_sh   = {cur_rem[`CALC_WIDTH-2:0], cur_rad[`CALC_WIDTH-1:`CALC_WIDTH-2]};
	end

	assign alu.req  = go || (state == U_BUSY);
	assign alu.sub  = 1'b1;
	assign alu.op_a = rem_sh;
	// Trial value 4 * root + 1
	assign alu.op_b = {1'b0, cur_root[`CALC_WIDTH-3:0], 2'b01};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= U_IDLE;
			step_cnt <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (alu.req && alu.gnt) begin
				if (cur_cnt == LAST) begin
					state <= U_IDLE;
					done  <= 1'b1;
				end else begin
					state    <= U_BUSY;
					step_cnt <= cur_cnt + 1'b1;
				end
			end else if (go) begin
				state    <= U_BUSY;
				step_cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alu.req && alu.gnt) begin
			rad_q  <= {cur_rad[`CALC_WIDTH-3:0], 2'b00};
			root_q <= {cur_root[`CALC_WIDTH-2:0], alu.no_borrow};
			rem_q  <= alu.no_borrow ? alu.res[`CALC_WIDTH-1:0] : rem_sh[`CALC_WIDTH-1:0];
		end else if (go) begin
			rad_q  <= cur_rad;
			root_q <= cur_root;
			rem_q  <= cur_rem;
		end
	end

	assign root = root_q;
	assign rem  = rem_q;

endmodule

// ==== calc_control.sv ====
`timescale 1ns/1ps
`include "calc_macros.svh"

module calc_control import calc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  data_t data,
	input  logic  load,
	input  logic  start,
	input  op_t   op,
	output logic  mult_go,
	output logic  div_go,
	output logic  sqrt_go,
	output data_t op_x,
	output data_t op_y,
	input  logic  mult_done,
	input  logic  div_done,
	input  logic  sqrt_done,
	input  prod_t mult_prod,
	input  data_t div_quot,
	input  data_t div_rem,
	input  data_t sqrt_root,
	input  data_t sqrt_rem,
	output logic  ready,
	output logic  error,
	output data_t result,
	output data_t remainder
);

	ctrl_state_t state;
	op_t         op_q;
	logic        load_x;
	logic        load_y;
	logic        unit_done;
	logic        cap_error;
	data_t       cap_result;
	data_t       cap_rem;

	// Start wins over a load in the same cycle
	assign load_x = load && ((state == S_IDLE) || (state == S_DONE) ||
		((state == S_READY_OPS) && !start));
	assign load_y = load && (state == S_HAVE_X);

	always_ff @(posedge clk) begin
		if (load_x) begin
			op_x <= data;
		end
		if (load_y) begin
			op_y <= data;
		end
	end

	// Result of the unit that was launched
	always_comb begin
		unit_done  = 1'b0;
		cap_error  = 1'b0;
		cap_result = '0;
		cap_rem    = '0;
		case (op_q)
			OP_MUL: begin
				unit_done  = mult_done;
				cap_error  = |mult_prod[2*`CALC_WIDTH-1:`CALC_WIDTH];
				cap_result = cap_error ? '0 : mult_prod[`CALC_WIDTH-1:0];
			end
			OP_DIV: begin
				unit_done  = div_done;
				cap_result = div_quot;
				cap_rem    = div_rem;
			end
			OP_SQRT: begin
				unit_done  = sqrt_done;
				cap_result = sqrt_root;
				cap_rem    = sqrt_rem;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			op_q      <= OP_MUL;
			mult_go   <= 1'b0;
			div_go    <= 1'b0;
			sqrt_go   <= 1'b0;
			ready     <= 1'b0;
			error     <= 1'b0;
			result    <= '0;
			remainder <= '0;
		end else begin
			mult_go <= 1'b0;
			div_go  <= 1'b0;
			sqrt_go <= 1'b0;
			ready   <= 1'b0;
			error   <= 1'b0;
			case (state)
				S_IDLE, S_DONE: begin
					state <= load_x ? S_HAVE_X : S_IDLE;
				end
				S_HAVE_X: begin
					if (load_y) begin
						state <= S_READY_OPS;
					end
				end
				S_READY_OPS: begin
					if (start) begin
						op_q  <= op;
						state <= S_CHECK;
					end else if (load_x) begin
						state <= S_HAVE_X;
					end
				end
				S_CHECK: begin
					state <= S_RUN;
					case (op_q)
						OP_MUL:  mult_go <= 1'b1;
						OP_SQRT: sqrt_go <= 1'b1;
						OP_DIV: begin
							if (op_y != '0) begin
								div_go <= 1'b1;
							end else begin
								ready     <= 1'b1;
								error     <= 1'b1;
								result    <= '0;
								remainder <= '0;
								state     <= S_DONE;
							end
						end
						default: begin
							// Unknown opcode, nothing to launch
							ready     <= 1'b1;
							error     <= 1'b1;
							result    <= '0;
							remainder <= '0;
							state     <= S_DONE;
						end
					endcase
				end
				S_RUN: begin
					if (unit_done) begin
						ready     <= 1'b1;
						error     <= cap_error;
						result    <= cap_result;
						remainder <= cap_rem;
						state     <= S_DONE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== bcd_display.sv ====
`timescale 1ns/1ps
`include "calc_macros.svh"

module bcd_display import calc_pkg::*; (
	input  data_t value,
	output seg_t  ones,
	output seg_t  tens,
	output seg_t  hundreds,
	output seg_t  thousands,
	output seg_t  ten_thousands
);

	logic [`CALC_WIDTH+4*`CALC_DIGITS-1:0] dabble;
	bcd_t digit [`CALC_DIGITS];

	// Common cathode, segment on when the bit is high
	function automatic seg_t seg_decode(input bcd_t d);
		case (d)
			4'd0:    seg_decode = 7'h3F;
			4'd1:    seg_decode = 7'h06;
			4'd2:    seg_decode = 7'h5B;
			4'd3:    seg_decode = 7'h4F;
			4'd4:    seg_decode = 7'h66;
			4'd5:    seg_decode = 7'h6D;
			4'd6:    seg_decode = 7'h7D;
			4'd7:    seg_decode = 7'h07;
			4'd8:    seg_decode = 7'h7F;
			4'd9:    seg_decode = 7'h6F;
			default: seg_decode = 7'h00;
		endcase
	endfunction

	// Double dabble, add 3 to any digit at 5 or above before each shift
	always_comb begin
		dabble = '0;
		dabble[`CALC_WIDTH-1:0] = value;
		for (int i = 0; i < `CALC_WIDTH; i++) begin
			for (int d = 0; d < `CALC_DIGITS; d++) begin
				if (dabble[`CALC_WIDTH+4*d +: 4] >= 4'd5) begin
					dabble[`CALC_WIDTH+4*d +: 4] = dabble[`CALC_WIDTH+4*d +: 4] + 4'd3;
				end
			end
			dabble = dabble << 1;
		end
		for (int d = 0; d < `CALC_DIGITS; d++) begin
			digit[d] = dabble[`CALC_WIDTH+4*d +: 4];
		end
	end

	assign ones          = seg_decode(digit[0]);
	assign tens          = seg_decode(digit[1]);
	assign hundreds      = seg_decode(digit[2]);
	assign thousands     = seg_decode(digit[3]);
	assign ten_thousands = seg_decode(digit[4]);

endmodule

// ==== calc_top.sv ====
`timescale 1ns/1ps

module calc_top import calc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  data_t data,
	input  logic  load,
	input  logic  start,
	input  op_t   op,
	output logic  ready,
	output logic  error,
	output data_t result,
	output data_t remainder,
	output seg_t  seg_ones,
	output seg_t  seg_tens,
	output seg_t  seg_hundreds,
	output seg_t  seg_thousands,
	output seg_t  seg_ten_thousands
);

	logic  mult_go;
	logic  div_go;
	logic  sqrt_go;
	logic  mult_done;
	logic  div_done;
	logic  sqrt_done;
	data_t op_x;
	data_t op_y;
	prod_t mult_prod;
	data_t div_quot;
	data_t div_rem;
	data_t sqrt_root;
	data_t sqrt_rem;

	alu_share_if mult_alu ();
	alu_share_if div_alu ();
	alu_share_if sqrt_alu ();

	calc_control i_calc_control (
		.clk(clk), .rst_n(rst_n), .data(data), .load(load), .start(start), .op(op),
		.mult_go(mult_go), .div_go(div_go), .sqrt_go(sqrt_go), .op_x(op_x), .op_y(op_y),
		.mult_done(mult_done), .div_done(div_done), .sqrt_done(sqrt_done),
		.mult_prod(mult_prod), .div_quot(div_quot), .div_rem(div_rem),
		.sqrt_root(sqrt_root), .sqrt_rem(sqrt_rem),
		.ready(ready), .error(error), .result(result), .remainder(remainder)
	);

	// X is the multiplicand, the dividend and the radicand
	seq_mult i_seq_mult (
		.clk(clk), .rst_n(rst_n), .go(mult_go), .mc(op_x), .mp(op_y),
		.done(mult_done), .prod(mult_prod), .alu(mult_alu)
	);

	seq_div i_seq_div (
		.clk(clk), .rst_n(rst_n), .go(div_go), .dividend(op_x), .divisor(op_y),
		.done(div_done), .quot(div_quot), .rem(div_rem), .alu(div_alu)
	);

	seq_sqrt i_seq_sqrt (
		.clk(clk), .rst_n(rst_n), .go(sqrt_go), .radicand(op_x),
		.done(sqrt_done), .root(sqrt_root), .rem(sqrt_rem), .alu(sqrt_alu)
	);

	alu_arbiter i_alu_arbiter (
		.clk(clk), .rst_n(rst_n),
		.mult_port(mult_alu), .div_port(div_alu), .sqrt_port(sqrt_alu)
	);

	bcd_display i_bcd_display (
		.value(result), .ones(seg_ones), .tens(seg_tens), .hundreds(seg_hundreds),
		.thousands(seg_thousands), .ten_thousands(seg_ten_thousands)
	);

endmodule

// ==== calc_properties.sv ====
`timescale 1ns/1ps

module calc_properties (
	input logic       clk,
	input logic       rst_n,
	input logic       start,
	input logic       ready,
	input logic       error,
	input logic       mult_req,
	input logic       div_req,
	input logic       sqrt_req,
	input logic [2:0] last_gnt
);

	int unsigned fail_count = 0;

	ready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		ready |=> !ready)
		else begin
			fail_count++;
			$error("ready stayed high for more than one cycle");
		end

	error_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
		error |-> ready)
		else begin
			fail_count++;
			$error("error raised without ready");
		end

	// Shared adder has one owner at a time and no unit waits for it
	single_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(last_gnt) && (last_gnt == $past({sqrt_req, div_req, mult_req})))
		else begin
			fail_count++;
			$error("adder grant was not given to exactly the one requesting unit");
		end

	// Fastest answer is the zero divisor in cycle 2
	min_latency: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !ready ##1 !ready)
		else begin
			fail_count++;
			$error("ready came earlier than two cycles after start");
		end

endmodule

bind calc_top calc_properties i_calc_properties (
	.clk(clk),
	.rst_n(rst_n),
	.start(start),
	.ready(ready),
	.error(error),
	.mult_req(mult_alu.req),
	.div_req(div_alu.req),
	.sqrt_req(sqrt_alu.req),
	.last_gnt(i_alu_arbiter.last_gnt)
);

// ==== tb_calc.sv ====
`timescale 1ns/1ps
`include "calc_macros.svh"

module tb_calc import calc_pkg::*; ();

	localparam int NUM_RAND = 50;
	// Random runs, two root extremes, two error cases, two strobe cases, one mid-run load
	localparam int NUM_TRANS = 3 * NUM_RAND + 2 + 2 + 2 + 1;
	localparam int CYCLE_LIMIT = NUM_TRANS * 25 + 100;
	localparam int READY_WAIT = 40;

	logic        clk;
	logic        rst_n;
	data_t       data;
	logic        load;
	logic        start;
	op_t         op;
	logic        ready;
	logic        error;
	data_t       result;
	data_t       remainder;
	seg_t        seg_ones;
	seg_t        seg_tens;
	seg_t        seg_hundreds;
	seg_t        seg_thousands;
	seg_t        seg_ten_thousands;
	logic [31:0] rng;
	int          cycle_count = 0;

	calc_top i_calc_top (
		.clk(clk), .rst_n(rst_n), .data(data), .load(load), .start(start), .op(op),
		.ready(ready), .error(error), .result(result), .remainder(remainder),
		.seg_ones(seg_ones), .seg_tens(seg_tens), .seg_hundreds(seg_hundreds),
		.seg_thousands(seg_thousands), .seg_ten_thousands(seg_ten_thousands)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped after an error");
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			fail_stop($sformatf("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT));
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Common cathode, bit 0 is segment a
	function automatic seg_t seg_pattern(input int d);
		case (d)
			0: return 7'b0111111;
			1: return 7'b0000110;
			2: return 7'b1011011;
			3: return 7'b1001111;
			4: return 7'b1100110;
			5: return 7'b1101101;
			6: return 7'b1111101;
			7: return 7'b0000111;
			8: return 7'b1111111;
			9: return 7'b1101111;
			default: return 7'b0000000;
		endcase
	endfunction

	function automatic int floor_sqrt(input int n);
		int r;
		r = 0;
		while ((r + 1) * (r + 1) <= n) begin
			r++;
		end
		return r;
	endfunction

	task automatic check_value(input string what, input int actual, input int expected);
		if (actual !== expected) begin
			fail_stop($sformatf("FAIL at %0d ns: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// Returns 2 ns after the edge that samples start
	task automatic launch(input data_t x, input data_t y, input op_t opc);
		next_cycle();
		data = x;
		load = 1'b1;
		next_cycle();
		data = y;
		next_cycle();
		load  = 1'b0;
		op    = opc;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
	endtask

	// Sampled at the falling edge, so a count of n is the value seen at rising edge n
	task automatic wait_ready(input int first, output int cycles);
		int n;
		n = first;
		do begin
			@(negedge clk);
			n++;
			if (n > READY_WAIT) begin
				fail_stop($sformatf("No ready pulse within %0d cycles after start", READY_WAIT));
			end
		end while (!ready);
		cycles = n;
	endtask

	task automatic check_display(input int value);
		seg_t segs [`CALC_DIGITS];
		int   v;
		segs[0] = seg_ones;
		segs[1] = seg_tens;
		segs[2] = seg_hundreds;
		segs[3] = seg_thousands;
		segs[4] = seg_ten_thousands;
		v = value;
		for (int d = 0; d < `CALC_DIGITS; d++) begin
			check_value($sformatf("segments of digit %0d", d), int'(segs[d]),
				int'(seg_pattern(v % 10)));
			v = v / 10;
		end
	endtask

	task automatic check_outcome(input string name, input int cyc, input int exp_result,
		input int exp_rem, input int exp_err, input int exp_cycles);
		check_value({name, " ready cycle"}, cyc, exp_cycles);
		check_value({name, " error"}, int'(error), exp_err);
		check_value({name, " result"}, int'(result), exp_result);
		check_value({name, " remainder"}, int'(remainder), exp_rem);
		check_display(exp_result);
	endtask

	task automatic run_op(input string name, input int x, input int y, input op_t opc,
		input int exp_result, input int exp_rem, input int exp_err, input int exp_cycles);
		int cyc;
		launch(data_t'(x), data_t'(y), opc);
		wait_ready(0, cyc);
		check_outcome(name, cyc, exp_result, exp_rem, exp_err, exp_cycles);
	endtask

	task automatic after_reset_check();
		check_value("ready after reset", int'(ready), 0);
		check_value("error after reset", int'(error), 0);
		check_value("result after reset", int'(result), 0);
	endtask

	// Products kept below 65536
	task automatic multiply_random();
		int a;
		int b;
		int limit;
		for (int i = 0; i < NUM_RAND; i++) begin
			a = int'(next_rand() % 65536);
			a = a >> int'(next_rand() % 16);
			limit = (a == 0) ? 65535 : 65535 / a;
			b = int'(next_rand() % (limit + 1));
			run_op($sformatf("mul %0d*%0d", a, b), a, b, OP_MUL, a * b, 0, 0, 19);
		end
	endtask

	task automatic divide_random();
		int a;
		int b;
		for (int i = 0; i < NUM_RAND; i++) begin
			a = int'(next_rand() % 65536);
			b = int'(next_rand() % 65536) >> int'(next_rand() % 16);
			if (b == 0) begin
				b = 1;
			end
			run_op($sformatf("div %0d/%0d", a, b), a, b, OP_DIV, a / b, a % b, 0, 19);
		end
	endtask

	task automatic sqrt_one(input int n);
		int r;
		r = floor_sqrt(n);
		run_op($sformatf("sqrt %0d", n), n, 1, OP_SQRT, r, n - r * r, 0, 11);
	endtask

	task automatic sqrt_random();
		sqrt_one(0);
		sqrt_one(65535);
		for (int i = 0; i < NUM_RAND; i++) begin
			sqrt_one(int'(next_rand() % 65536));
		end
	endtask

	task automatic error_cases();
		run_op("divide by zero", 1234, 0, OP_DIV, 0, 0, 1, 2);
		run_op("overflow 300*300", 300, 300, OP_MUL, 0, 0, 1, 19);
	endtask

	// Start with only X loaded is dropped, the following Y load completes the pair
	task automatic ignored_strobes();
		int cyc;
		next_cycle();
		data = 16'd1000;
		load = 1'b1;
		next_cycle();
		load  = 1'b0;
		op    = OP_DIV;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		repeat (30) begin
			@(negedge clk);
			if (ready) begin
				fail_stop("Ready pulsed after a start with only one operand loaded");
			end
		end
		next_cycle();
		data = 16'd7;
		load = 1'b1;
		next_cycle();
		load  = 1'b0;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		wait_ready(0, cyc);
		check_outcome("div 1000/7 after late load", cyc, 142, 6, 0, 19);
	endtask

	task automatic load_during_run();
		int cyc;
		launch(16'd250, 16'd200, OP_MUL);
		repeat (4) next_cycle();
		// Sampled at rising edge 5, while the multiplier runs
		data = 16'h0BAD;
		load = 1'b1;
		next_cycle();
		load = 1'b0;
		wait_ready(5, cyc);
		check_outcome("mul 250*200 with load during run", cyc, 50000, 0, 0, 19);
	endtask

	initial begin
		rng   = 32'h8346_dc37;
		rst_n = 1'b0;
		data  = '0;
		load  = 1'b0;
		start = 1'b0;
		op    = OP_MUL;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;

		after_reset_check();
		multiply_random();
		divide_random();
		sqrt_random();
		error_cases();
		ignored_strobes();
		load_during_run();
		repeat (3) next_cycle();

		if (i_calc_top.i_calc_properties.fail_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			fail_stop("An assertion failed during the run");
		end
	end

endmodule

// ==== calc.f ====
+incdir+.
calc_pkg.sv
alu_share_if.sv
alu_arbiter.sv
seq_mult.sv
seq_div.sv
seq_sqrt.sv
calc_control.sv
bcd_display.sv
calc_top.sv
calc_properties.sv
tb_calc.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_calc \
	-f calc.f --Mdir obj_dir -o sim_calc
./obj_dir/sim_calc | tee sim.log

if grep -q "Result: PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
